// File: Makefile
# Verilator simulation of the UART debug monitor

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_debug_monitor -f project.f -Mdir obj_dir
	./obj_dir/Vtb_debug_monitor > sim.log 2>&1; status=$$?; cat sim.log; test $$status -eq 0
	! grep -q "Test FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/debug_monitor_props.sv
/* sequencer handshake checks */
`timescale 1ns/100ps
module debug_monitor_props (
    input logic                  clk_in,
    input logic                  reset,
    input logic                  i_req,
    input debug_pkg::debug_cmd_t i_cmd,
    input logic                  o_ack,
    input logic                  o_tx_start,
    input logic                  i_tx_busy
);

    // ack drops one cycle after req has fallen
    property ack_follows_req;
        @(posedge clk_in) disable iff (reset)
            o_ack |-> (i_req || $past(i_req));
    endproperty

    // command may not move while the request waits for ack
    property cmd_held_until_ack;
        @(posedge clk_in) disable iff (reset)
            (i_req && !o_ack) |=> (!i_req || $stable(i_cmd));
    endproperty

    property start_only_when_free;
        @(posedge clk_in) disable iff (reset)
            o_tx_start |-> !i_tx_busy;
    endproperty

    assert property (ack_follows_req) else $error("cmd_ack high without cmd_req");
    assert property (cmd_held_until_ack) else $error("cmd changed before cmd_ack");
    assert property (start_only_when_free) else $error("tx_start while tx_busy");

endmodule

// File: dv/tb_debug_monitor.sv
/* debug monitor testbench */
`timescale 1ns/100ps
module tb_debug_monitor;
    import debug_pkg::*;

    localparam int DATA_WIDTH = 32;
    localparam int TICKS_PER_BIT = 8;
    localparam int DUMP_PERIOD = 2000;
    localparam int RESET_CYCLES = 8;
    localparam int DUMP_BYTES = DATA_WIDTH / 8 + 1;
    localparam int FRAME_CYCLES = 10 * TICKS_PER_BIT;
    localparam int TIMEOUT_CYCLES = 8 * DUMP_PERIOD;

    logic clk_in;
    logic reset;
    logic i_rx;
    logic [DATA_WIDTH-1:0] i_data;
    logic o_tx;
    logic [7:0] o_cmd_byte;
    logic o_cmd_valid;

    int cycle_cnt;
    int frames_seen;
    int dumps_checked;
    int echo_cnt;
    int timed_out;
    int err_main;
    int err_rx;
    int err_dump;
    int err_echo;
    logic [7:0] rx_q[$];
    logic [7:0] sent_cmd[$];
    logic [DATA_WIDTH-1:0] exp_words[$];

    debug_monitor_top #(
        .DATA_WIDTH   (DATA_WIDTH),
        .TICKS_PER_BIT(TICKS_PER_BIT),
        .DUMP_PERIOD  (DUMP_PERIOD)
    ) DUT (
        .clk_in     (clk_in),
        .reset      (reset),
        .i_rx       (i_rx),
        .i_data     (i_data),
        .o_tx       (o_tx),
        .o_cmd_byte (o_cmd_byte),
        .o_cmd_valid(o_cmd_valid)
    );

    bind debug_dump_sequencer debug_monitor_props u_props (
        .clk_in    (clk_in),
        .reset     (reset),
        .i_req     (i_req),
        .i_cmd     (i_cmd),
        .o_ack     (o_ack),
        .o_tx_start(o_tx_start),
        .i_tx_busy (i_tx_busy)
    );

    always #5 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // expected byte idx of a dump with data bytes MSB first and a newline last
    function automatic logic [7:0] expected_byte(input logic [DATA_WIDTH-1:0] word, input int idx);
        if (idx < DATA_WIDTH / 8) begin
            return word[DATA_WIDTH-1-8*idx -: 8];
        end
        return 8'h0A;
    endfunction

    task automatic finish_run();
        int total;
        total = err_main + err_rx + err_dump + err_echo + timed_out;
        $display("errors %0d (main %0d, o_tx %0d, dump %0d, echo %0d, timeout %0d), dumps %0d",
                 total, err_main, err_rx, err_dump, err_echo, timed_out, dumps_checked);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    task automatic new_word();
        logic [DATA_WIDTH-1:0] word;
        word = $urandom();
        @(posedge clk_in);
        i_data <= word;
        exp_words.push_back(word);
    endtask

    // host side UART sending 8N1 frames LSB first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        int echoes;
        int waited;
        frame = {1'b1, b, 1'b0};
        echoes = echo_cnt;
        sent_cmd.push_back(b);
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_in);
            i_rx <= frame[i];
            repeat (TICKS_PER_BIT - 1) @(posedge clk_in);
        end
        waited = 0;
        while (echo_cnt == echoes && waited < 2 * TICKS_PER_BIT) begin
            @(posedge clk_in);
            waited++;
        end
        assert (echo_cnt > echoes) else begin
            err_main++;
            $display("host byte 0x%h produced no o_cmd_valid strobe", b);
        end
    endtask

    task automatic wait_dumps(input int n);
        int waited;
        waited = 0;
        while (dumps_checked < n && waited < 2 * DUMP_PERIOD) begin
            @(posedge clk_in);
            waited++;
        end
        assert (dumps_checked >= n) else begin
            err_main++;
            $display("dump %0d did not arrive in time", n);
        end
    endtask

    task automatic wait_link_idle();
        int high_cnt;
        high_cnt = 0;
        while (high_cnt < FRAME_CYCLES) begin
            @(negedge clk_in);
            high_cnt = (o_tx === 1'b1) ? high_cnt + 1 : 0;
        end
    endtask

    // serial monitor on o_tx
    initial begin
        logic [7:0] rx_b;
        forever begin
            @(negedge clk_in);
            if (!reset && o_tx === 1'b0) begin
                assert (frames_seen > 0 || cycle_cnt >= RESET_CYCLES + DUMP_PERIOD) else begin
                    err_rx++;
                    $display("frame on o_tx at cycle %0d, before the first period", cycle_cnt);
                end
                frames_seen++;
                repeat (TICKS_PER_BIT / 2) @(negedge clk_in);
                assert (o_tx == 1'b0) else begin
                    err_rx++;
                    $display("start bit on o_tx did not hold to mid-bit");
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (TICKS_PER_BIT) @(negedge clk_in);
                    rx_b[i] = o_tx;
                end
                repeat (TICKS_PER_BIT) @(negedge clk_in);
                assert (o_tx == 1'b1) else begin
                    err_rx++;
                    $display("stop bit on o_tx was low");
                end
                rx_q.push_back(rx_b);
            end
        end
    end

    // compares every complete dump with the reference
    initial begin
        int base;
        logic [DATA_WIDTH-1:0] word;
        base = 0;
        forever begin
            @(negedge clk_in);
            if (rx_q.size() >= base + DUMP_BYTES) begin
                assert (exp_words.size() > dumps_checked) else begin
                    err_dump++;
                    $display("a dump arrived with no data word expected");
                end
                if (exp_words.size() > dumps_checked) begin
                    word = exp_words[dumps_checked];
                    for (int i = 0; i < DUMP_BYTES; i++) begin
                        assert (rx_q[base+i] == expected_byte(word, i)) else begin
                            err_dump++;
                            $display("FAILED o_tx byte %0d of dump %0d: got 0x%h expected 0x%h",
                                     i, dumps_checked, rx_q[base+i], expected_byte(word, i));
                        end
                    end
                end
                dumps_checked++;
                base += DUMP_BYTES;
            end
        end
    end

    // each host byte echoes once on o_cmd_byte
    initial begin
        forever begin
            @(negedge clk_in);
            if (o_cmd_valid === 1'b1) begin
                assert (echo_cnt < sent_cmd.size()) else begin
                    err_echo++;
                    $display("o_cmd_valid strobe with no host byte sent");
                end
                if (echo_cnt < sent_cmd.size()) begin
                    assert (o_cmd_byte == sent_cmd[echo_cnt]) else begin
                        err_echo++;
                        $display("FAILED o_cmd_byte: got 0x%h expected 0x%h",
                                 o_cmd_byte, sent_cmd[echo_cnt]);
                    end
                end
                echo_cnt++;
                @(negedge clk_in);
                assert (o_cmd_valid == 1'b0) else begin
                    err_echo++;
                    $display("o_cmd_valid stayed high for more than one cycle");
                end
            end
        end
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        timed_out = 1;
        $display("run stopped at cycle %0d before the tests finished", cycle_cnt);
        finish_run();
    end

    initial begin
        int frames_before;
        void'($urandom(86214));
        clk_in = 1'b0;
        reset = 1'b1;
        i_rx = 1'b1;
        i_data = '0;
        repeat (RESET_CYCLES) @(posedge clk_in);
        reset <= 1'b0;

        // two periodic dumps with the word changed while the link is idle
        new_word();
        wait_dumps(1);
        wait_link_idle();
        new_word();
        wait_dumps(2);
        wait_link_idle();

        // pause and an unknown byte followed by silence over two periods
        send_byte(CHAR_PAUSE);
        send_byte(8'h78);
        frames_before = frames_seen;
        repeat (2 * DUMP_PERIOD) @(posedge clk_in);
        assert (frames_seen == frames_before) else begin
            err_main++;
            $display("frame sent on o_tx while paused");
        end

        // one snapshot while paused
        new_word();
        send_byte(CHAR_SNAPSHOT);
        wait_dumps(3);
        wait_link_idle();
        repeat (DUMP_PERIOD / 2) @(posedge clk_in);
        assert (frames_seen == frames_before + DUMP_BYTES) else begin
            err_main++;
            $display("snapshot while paused did not give exactly one dump");
        end

        // resume and see periodic dumps again
        new_word();
        send_byte(CHAR_RESUME);
        wait_dumps(4);
        wait_link_idle();
        new_word();
        wait_dumps(5);
        wait_link_idle();

        assert (echo_cnt == sent_cmd.size()) else begin
            err_main++;
            $display("%0d host bytes sent but %0d echoed", sent_cmd.size(), echo_cnt);
        end
        finish_run();
    end

endmodule

// File: project.f
source/debug_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/debug_cmd_decode.sv
source/debug_dump_sequencer.sv
source/debug_monitor_top.sv
dv/debug_monitor_props.sv
dv/tb_debug_monitor.sv

// File: source/debug_cmd_decode.sv
/* host command decoder */
`timescale 1ns/100ps
module debug_cmd_decode (
    input  logic                  clk_in,
    input  logic                  reset,
    input  logic [7:0]            i_byte,
    input  logic                  i_valid,
    output logic                  o_req,
    output debug_pkg::debug_cmd_t o_cmd,
    input  logic                  i_ack
);
    import debug_pkg::*;

    logic known;
    cmd_op_t op_next;
    logic hs_busy;
    logic take;

    always_comb begin
        known = 1'b1;
        op_next = CMD_PAUSE;
        case (i_byte)
            CHAR_PAUSE: op_next = CMD_PAUSE;
            CHAR_RESUME: op_next = CMD_RESUME;
            CHAR_SNAPSHOT: op_next = CMD_SNAPSHOT;
            default: known = 1'b0;
        endcase
    end

    // handshake runs until ack has fallen again
    assign hs_busy = o_req | i_ack;
    assign take = i_valid & known & ~hs_busy;

    // requester side of the four-phase handshake
    always_ff @(posedge clk_in) begin
        if (reset) begin
            o_req <= 1'b0;
        end else if (o_req && i_ack) begin
            o_req <= 1'b0;
        end else if (take) begin
            o_req <= 1'b1;
        end
    end

    // command held stable while req is up
    always_ff @(posedge clk_in) begin
        if (take) begin
            o_cmd.op <= op_next;
        end
    end

endmodule

// File: source/debug_dump_sequencer.sv
/* snapshot dump sequencer */
`timescale 1ns/100ps
module debug_dump_sequencer #(
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned DUMP_PERIOD = 67000000
) (
    input  logic                  clk_in,
    input  logic                  reset,
    input  logic                  i_req,
    input  debug_pkg::debug_cmd_t i_cmd,
    output logic                  o_ack,
    input  logic [DATA_WIDTH-1:0] i_data,
    output logic                  o_tx_start,
    output logic [7:0]            o_tx_byte,
    input  logic                  i_tx_busy
);
    import debug_pkg::*;

    localparam int unsigned NUM_BYTES = DATA_WIDTH / UART_DATA_BITS;
    localparam int unsigned POS_W = $clog2(NUM_BYTES + 1);
    localparam int unsigned PER_W = $clog2(DUMP_PERIOD + 1);
    localparam logic [PER_W-1:0] PERIOD_LAST = PER_W'(DUMP_PERIOD - 1);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_START,
        SEQ_SEND,
        SEQ_WAIT
    } seq_state_t;

    seq_state_t state;
    logic [PER_W-1:0] period_cnt;
    logic tick;
    logic paused;
    logic pending;
    logic start_dump;
    logic closing;
    logic [POS_W-1:0] bytes_left;
    logic [DATA_WIDTH-1:0] data_copy;

    // one-cycle tick every DUMP_PERIOD cycles
    always_ff @(posedge clk_in) begin
        if (reset) begin
            period_cnt <= '0;
            tick <= 1'b0;
        end else if (period_cnt == PERIOD_LAST) begin
            period_cnt <= '0;
            tick <= 1'b1;
        end else begin
            period_cnt <= period_cnt + 1'b1;
            tick <= 1'b0;
        end
    end

    // ticks outside idle are lost, a pending snapshot is not
    assign start_dump = (state == SEQ_IDLE) && (pending || (tick && !paused));

    // responder side of the handshake
    always_ff @(posedge clk_in) begin
        if (reset) begin
            o_ack <= 1'b0;
            paused <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (start_dump) begin
                pending <= 1'b0;
            end
            if (i_req && !o_ack) begin
                o_ack <= 1'b1;
                case (i_cmd.op)
                    CMD_PAUSE: paused <= 1'b1;
                    CMD_RESUME: paused <= 1'b0;
                    CMD_SNAPSHOT: pending <= 1'b1;
                    default: ;
                endcase
            end else if (!i_req) begin
                o_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= SEQ_IDLE;
            o_tx_start <= 1'b0;
            closing <= 1'b0;
            bytes_left <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (start_dump) begin
                        data_copy <= i_data;
                        bytes_left <= POS_W'(NUM_BYTES);
                        state <= SEQ_START;
                    end
                end
                SEQ_START: begin
                    // all data bytes out, newline is next
                    closing <= (bytes_left == '0);
                    state <= SEQ_SEND;
                end
                SEQ_SEND: begin
                    if (!i_tx_busy) begin
                        o_tx_byte <= closing ? CHAR_NEWLINE
                                             : data_copy[DATA_WIDTH-1 -: UART_DATA_BITS];
                        o_tx_start <= 1'b1;
                        state <= SEQ_WAIT;
                    end
                end
                default: begin
                    o_tx_start <= 1'b0;
                    // busy shows up one cycle after start
                    if (!o_tx_start && !i_tx_busy) begin
                        if (closing) begin
                            state <= SEQ_IDLE;
                        end else begin
                            data_copy <= data_copy << UART_DATA_BITS;
                            bytes_left <= bytes_left - 1'b1;
                            state <= SEQ_START;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: source/debug_monitor_top.sv
/* uart debug monitor */
`timescale 1ns/100ps
module debug_monitor_top #(
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned TICKS_PER_BIT = 191,
    parameter int unsigned DUMP_PERIOD = 67000000
) (
    input  logic                  clk_in,
    input  logic                  reset,
    input  logic                  i_rx,
    input  logic [DATA_WIDTH-1:0] i_data,
    output logic                  o_tx,
    output logic [7:0]            o_cmd_byte,
    output logic                  o_cmd_valid
);
    import debug_pkg::*;

    logic [7:0] rx_byte;
    logic rx_valid;
    logic cmd_req;
    logic cmd_ack;
    debug_cmd_t cmd;
    logic tx_start;
    logic [7:0] tx_byte;
    logic tx_busy;

    // every received byte is visible, known or not
    assign o_cmd_byte = rx_byte;
    assign o_cmd_valid = rx_valid;

    uart_rx #(
        .TICKS_PER_BIT(TICKS_PER_BIT)
    ) u_rx (
        .clk_in (clk_in),
        .reset  (reset),
        .i_rx   (i_rx),
        .o_byte (rx_byte),
        .o_valid(rx_valid)
    );

    debug_cmd_decode u_decode (
        .clk_in (clk_in),
        .reset  (reset),
        .i_byte (rx_byte),
        .i_valid(rx_valid),
        .o_req  (cmd_req),
        .o_cmd  (cmd),
        .i_ack  (cmd_ack)
    );

    debug_dump_sequencer #(
        .DATA_WIDTH (DATA_WIDTH),
        .DUMP_PERIOD(DUMP_PERIOD)
    ) u_seq (
        .clk_in    (clk_in),
        .reset     (reset),
        .i_req     (cmd_req),
        .i_cmd     (cmd),
        .o_ack     (cmd_ack),
        .i_data    (i_data),
        .o_tx_start(tx_start),
        .o_tx_byte (tx_byte),
        .i_tx_busy (tx_busy)
    );

    uart_tx #(
        .TICKS_PER_BIT(TICKS_PER_BIT)
    ) u_tx (
        .clk_in (clk_in),
        .reset  (reset),
        .i_start(tx_start),
        .i_byte (tx_byte),
        .o_busy (tx_busy),
        .o_tx   (o_tx)
    );

endmodule

// File: source/debug_pkg.sv
/* debug monitor shared types */
package debug_pkg;

    // bits per uart frame payload
    localparam int unsigned UART_DATA_BITS = 8;

    // host command characters
    localparam logic [7:0] CHAR_PAUSE = 8'h50;
    localparam logic [7:0] CHAR_RESUME = 8'h52;
    localparam logic [7:0] CHAR_SNAPSHOT = 8'h53;

    // terminates every dump
    localparam logic [7:0] CHAR_NEWLINE = 8'h0A;

    typedef enum logic [1:0] {
        CMD_PAUSE = 2'd0,
        CMD_RESUME = 2'd1,
        CMD_SNAPSHOT = 2'd2
    } cmd_op_t;

    // decoder to sequencer command
    typedef struct packed {
        cmd_op_t op;
    } debug_cmd_t;

endpackage

// File: source/uart_rx.sv
/* uart receiver, 8N1 */
`timescale 1ns/100ps
module uart_rx #(
    parameter int unsigned TICKS_PER_BIT = 191
) (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       i_rx,
    output logic [7:0] o_byte,
    output logic       o_valid
);
    import debug_pkg::*;

    localparam int unsigned CNT_W = $clog2(TICKS_PER_BIT + 1);
    localparam int unsigned BIT_W = $clog2(UART_DATA_BITS);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(TICKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(TICKS_PER_BIT / 2 - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(UART_DATA_BITS - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t state;
    logic [1:0] rx_sync;
    logic [CNT_W-1:0] tick_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic [UART_DATA_BITS-1:0] shift;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            // line idles high
            rx_sync <= 2'b11;
            state <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt <= '0;
            o_valid <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
            o_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_sync[1]) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // mid start bit, a high line here was only a glitch
                    if (tick_cnt == HALF_BIT) begin
                        tick_cnt <= '0;
                        bit_cnt <= '0;
                        state <= rx_sync[1] ? RX_IDLE : RX_DATA;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (tick_cnt == FULL_BIT) begin
                        tick_cnt <= '0;
                        // lsb first
                        shift <= {rx_sync[1], shift[UART_DATA_BITS-1:1]};
                        if (bit_cnt == LAST_BIT) begin
                            state <= RX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: begin
                    // stop bit must be high or the frame is dropped
                    if (tick_cnt == FULL_BIT) begin
                        tick_cnt <= '0;
                        state <= RX_IDLE;
                        if (rx_sync[1]) begin
                            o_byte <= shift;
                            o_valid <= 1'b1;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: source/uart_tx.sv
/* uart transmitter, 8N1 */
`timescale 1ns/100ps
module uart_tx #(
    parameter int unsigned TICKS_PER_BIT = 191
) (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       i_start,
    input  logic [7:0] i_byte,
    output logic       o_busy,
    output logic       o_tx
);
    import debug_pkg::*;

    localparam int unsigned CNT_W = $clog2(TICKS_PER_BIT + 1);
    localparam int unsigned IDX_W = $clog2(UART_DATA_BITS + 2);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(TICKS_PER_BIT - 1);
    // start bit is index 0, stop bit is the last index
    localparam logic [IDX_W-1:0] STOP_IDX = IDX_W'(UART_DATA_BITS + 1);

    logic [CNT_W-1:0] tick_cnt;
    logic [IDX_W-1:0] bit_idx;
    // data bits with the stop bit shifted in behind them
    logic [UART_DATA_BITS:0] shift;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            o_busy <= 1'b0;
            o_tx <= 1'b1;
            tick_cnt <= '0;
            bit_idx <= '0;
        end else if (!o_busy) begin
            if (i_start) begin
                shift <= {1'b1, i_byte};
                o_busy <= 1'b1;
                o_tx <= 1'b0;
                tick_cnt <= '0;
                bit_idx <= '0;
            end
        end else if (tick_cnt == FULL_BIT) begin
            tick_cnt <= '0;
            if (bit_idx == STOP_IDX) begin
                // line stays high after the stop bit
                o_busy <= 1'b0;
            end else begin
                o_tx <= shift[0];
                shift <= {1'b1, shift[UART_DATA_BITS:1]};
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

endmodule
